// ==== list.f ====
+incdir+test
src/fetch_pkg.sv
src/fetch_if.sv
src/line_buffer.sv
src/fetch_pointer.sv
src/packet_align.sv
src/fetch_align_top.sv
test/fetch_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f list.f --top-module fetch_tb -o fetch_sim

# a fatal stop exits nonzero, the search below decides the result
output=$(./obj_dir/fetch_sim || true)
echo "$output"

if echo "$output" | grep -q "Simulation PASSED"; then
    exit 0
else
    exit 1
fi

// ==== src/fetch_align_top.sv ====
`timescale 1ns/1ps

module fetch_align_top (
    input  logic                  clk,
    input  logic                  reset,

    // APB host port
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  fetch_pkg::apb_addr_t  paddr,
    input  logic [31:0]           pwdata,
    output logic [31:0]           prdata,
    output logic                  pready,
    output logic                  pslverr,

    // decode and control flow
    input  logic [7:0]            length,
    input  logic                  stall,
    input  logic                  init,
    input  fetch_pkg::bip_t       init_bip,
    input  logic                  resteer,
    input  fetch_pkg::bip_t       resteer_bip,
    input  logic                  branch_taken,
    input  fetch_pkg::bip_t       branch_bip,

    input  fetch_pkg::line_t      alt_packet,
    input  logic                  alt_select,

    output fetch_pkg::line_t      packet_out,
    output logic                  packet_valid,
    output fetch_pkg::bip_t       old_bip,
    output fetch_pkg::bip_t       new_bip
);

    fetch_pkg::line_array_t lines;
    logic [3:0]             line_valid;

    fetch_if u_fetch_if ();

    line_buffer u_line_buffer (
        .clk        (clk),
        .reset      (reset),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .lines      (lines),
        .line_valid (line_valid)
    );

    fetch_pointer u_fetch_pointer (
        .clk          (clk),
        .reset        (reset),
        .length       (length),
        .stall        (stall),
        .init         (init),
        .init_bip     (init_bip),
        .resteer      (resteer),
        .resteer_bip  (resteer_bip),
        .branch_taken (branch_taken),
        .branch_bip   (branch_bip),
        .line_valid   (line_valid),
        .ptr          (u_fetch_if.ptr)
    );

    packet_align u_packet_align (
        .clk          (clk),
        .reset        (reset),
        .lines        (lines),
        .alt_packet   (alt_packet),
        .alt_select   (alt_select),
        .align        (u_fetch_if.align),
        .packet_out   (packet_out),
        .packet_valid (packet_valid),
        .old_bip      (old_bip),
        .new_bip      (new_bip)
    );

endmodule

// ==== src/fetch_if.sv ====
`timescale 1ns/1ps

interface fetch_if;

    // pointer held in the BIP register
    fetch_pkg::bip_t old_bip;

    // start of the window for this cycle
    fetch_pkg::bip_t next_bip;

    // window valid and no stall
    logic accept;

    // decode back-pressure
    logic stall;

    modport ptr (
        output old_bip,
        output next_bip,
        output accept,
        output stall
    );

    modport align (
        input old_bip,
        input next_bip,
        input accept,
        input stall
    );

endinterface

// ==== src/fetch_pkg.sv ====
package fetch_pkg;

    ////////////////////////////////////////
    // buffer geometry
    ////////////////////////////////////////

    // four lines make the 64-byte circular buffer
    localparam int NUM_LINES = 4;

    // one 16-byte line, byte k in bits 8k+7:8k
    typedef logic [127:0] line_t;

    // line 0 sits in the low 128 bits
    typedef line_t [NUM_LINES-1:0] line_array_t;

    // byte pointer: [5:4] line, [3:0] byte in line
    typedef logic [5:0] bip_t;

    ////////////////////////////////////////
    // host side
    ////////////////////////////////////////

    typedef logic [7:0] apb_addr_t;

    // valid bits register, just above the line space
    localparam apb_addr_t STATUS_ADDR = 8'h40;

endpackage

// ==== src/fetch_pointer.sv ====
`timescale 1ns/1ps

module fetch_pointer (
    input  logic            clk,
    input  logic            reset,

    // from decode
    input  logic [7:0]      length,
    input  logic            stall,

    // control-flow targets, highest priority first
    input  logic            init,
    input  fetch_pkg::bip_t init_bip,
    input  logic            resteer,
    input  fetch_pkg::bip_t resteer_bip,
    input  logic            branch_taken,
    input  fetch_pkg::bip_t branch_bip,

    // from the line buffer
    input  logic [3:0]      line_valid,

    fetch_if.ptr            ptr
);

    fetch_pkg::bip_t bip_q;
    fetch_pkg::bip_t cf_bip;
    fetch_pkg::bip_t next_bip;
    logic [7:0]      bip_sum;
    logic            redirect;
    logic [1:0]      cur_line;
    logic [1:0]      nxt_line;
    logic            window_valid;
    logic            accept;
    logic            load_bip;

    ////////////////////////////////////////
    // next pointer
    ////////////////////////////////////////

    assign redirect = init || resteer || branch_taken;

    always_comb begin
        if (init) begin
            cf_bip = init_bip;
        end else if (resteer) begin
            cf_bip = resteer_bip;
        end else begin
            cf_bip = branch_bip;
        end
    end

    // low six bits wrap around the buffer
    assign bip_sum  = {2'b00, bip_q} + length;
    assign next_bip = redirect ? cf_bip : bip_sum[5:0];

    // window spans this line and the one after it
    assign cur_line     = next_bip[5:4];
    assign nxt_line     = cur_line + 2'd1;
    assign window_valid = line_valid[cur_line] && line_valid[nxt_line];

    assign accept   = window_valid && !stall;
    assign load_bip = accept || (redirect && !stall);

    always_ff @(posedge clk) begin
        if (reset) begin
            bip_q <= '0;
        end else if (load_bip) begin
            bip_q <= next_bip;
        end
    end

    assign ptr.old_bip  = bip_q;
    assign ptr.next_bip = next_bip;
    assign ptr.accept   = accept;
    assign ptr.stall    = stall;

endmodule

// ==== src/line_buffer.sv ====
`timescale 1ns/1ps

module line_buffer (
    input  logic                    clk,
    input  logic                    reset,

    // APB slave
    input  logic                    psel,
    input  logic                    penable,
    input  logic                    pwrite,
    input  fetch_pkg::apb_addr_t    paddr,
    input  logic [31:0]             pwdata,
    output logic [31:0]             prdata,
    output logic                    pready,
    output logic                    pslverr,

    // to the pointer and align stages
    output fetch_pkg::line_array_t  lines,
    output logic [3:0]              line_valid
);

    fetch_pkg::line_array_t lines_q;
    logic [fetch_pkg::NUM_LINES-1:0] valid_q;

    logic       access;
    logic       in_lines;
    logic       is_status;
    logic       wr_line;
    logic       wr_status;
    logic       rd_en;
    logic [1:0] line_sel;
    logic [1:0] word_sel;

    ////////////////////////////////////////
    // address decode
    ////////////////////////////////////////

    assign access    = psel && penable;
    assign in_lines  = paddr < fetch_pkg::STATUS_ADDR;
    assign is_status = paddr == fetch_pkg::STATUS_ADDR;
    assign line_sel  = paddr[5:4];
    assign word_sel  = paddr[3:2];

    assign wr_line   = access && pwrite && in_lines;
    assign wr_status = access && pwrite && is_status;
    assign rd_en     = access && !pwrite;

    // no wait states
    assign pready  = 1'b1;
    assign pslverr = access && !in_lines && !is_status;

    ////////////////////////////////////////
    // storage
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (wr_line) begin
            lines_q[line_sel][{word_sel, 5'b00000} +: 32] <= pwdata;
        end
    end

    // last word of a line marks it filled
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= '0;
        end else if (wr_line && word_sel == 2'd3) begin
            valid_q[line_sel] <= 1'b1;
        end else if (wr_status) begin
            valid_q <= valid_q & ~pwdata[fetch_pkg::NUM_LINES-1:0];
        end
    end

    // read mux
    always_comb begin
        prdata = '0;
        if (rd_en && in_lines) begin
            prdata = lines_q[line_sel][{word_sel, 5'b00000} +: 32];
        end else if (rd_en && is_status) begin
            prdata[fetch_pkg::NUM_LINES-1:0] = valid_q;
        end
    end

    assign lines      = lines_q;
    assign line_valid = valid_q;

endmodule

// ==== src/packet_align.sv ====
`timescale 1ns/1ps

module packet_align (
    input  logic                    clk,
    input  logic                    reset,
    input  fetch_pkg::line_array_t  lines,

    // substitute packet
    input  fetch_pkg::line_t        alt_packet,
    input  logic                    alt_select,

    fetch_if.align                  align,

    output fetch_pkg::line_t        packet_out,
    output logic                    packet_valid,
    output fetch_pkg::bip_t         old_bip,
    output fetch_pkg::bip_t         new_bip
);

    // one entry per shifter level, entry 0 is the raw buffer
    logic [6:0][511:0] rot_stage;
    fetch_pkg::line_t  window;
    fetch_pkg::line_t  packet_sel;

    ////////////////////////////////////////
    // byte rotator
    ////////////////////////////////////////

    assign rot_stage[0] = lines;

    // level n moves the buffer down by 2**n bytes when bit n is set
    for (genvar lvl = 0; lvl < 6; lvl++) begin : g_rot
        localparam int SH = 8 << lvl;

        assign rot_stage[lvl+1] = align.next_bip[lvl]
            ? {rot_stage[lvl][SH-1:0], rot_stage[lvl][511:SH]}
            : rot_stage[lvl];
    end

    // first 16 bytes from the pointer
    assign window     = rot_stage[6][127:0];
    assign packet_sel = alt_select ? alt_packet : window;

    ////////////////////////////////////////
    // output register
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            packet_out   <= '0;
            packet_valid <= 1'b0;
            old_bip      <= '0;
            new_bip      <= '0;
        end else if (!align.stall) begin
            if (align.accept) begin
                packet_out   <= packet_sel;
                packet_valid <= 1'b1;
                old_bip      <= align.old_bip;
                new_bip      <= align.next_bip;
            end else begin
                // missing line, keep the last packet but flag it
                packet_valid <= 1'b0;
            end
        end
    end

endmodule

// ==== test/fetch_model.svh ====
`ifndef FETCH_MODEL_SVH
`define FETCH_MODEL_SVH

// packet byte k is buffer byte bip+k, wrapping at 64
function automatic fetch_pkg::line_t rotate_window(fetch_pkg::line_array_t buffer,
                                                   fetch_pkg::bip_t bip);
    fetch_pkg::line_t pkt;
    int b;
    for (int k = 0; k < 16; k++) begin
        b = (int'(bip) + k) % 64;
        pkt[k*8 +: 8] = buffer[b/16][(b%16)*8 +: 8];
    end
    return pkt;
endfunction

// line under the pointer and the one after it
function automatic bit window_ok(logic [3:0] valid, fetch_pkg::bip_t bip);
    int ln;
    ln = int'(bip[5:4]);
    return valid[ln] && valid[(ln+1)%4];
endfunction

// init beats resteer beats branch, else step by length
function automatic fetch_pkg::bip_t next_ptr(fetch_pkg::bip_t bip, step_t s);
    if (s.redir[2]) begin
        return fetch_pkg::bip_t'(s.init_bip);
    end else if (s.redir[1]) begin
        return fetch_pkg::bip_t'(s.resteer_bip);
    end else if (s.redir[0]) begin
        return fetch_pkg::bip_t'(s.branch_bip);
    end
    return fetch_pkg::bip_t'((int'(bip) + s.length) % 64);
endfunction

`endif

// ==== test/fetch_tb.sv ====
`timescale 1ns/1ps

module fetch_tb;

    localparam int TIMEOUT = 20;

    // redir holds init in bit 2, resteer in bit 1 and branch in bit 0
    typedef struct packed {
        int length;
        int stall;
        int redir;
        int init_bip;
        int resteer_bip;
        int branch_bip;
        int alt;
        int clear;
        int refill;
    } step_t;

    `include "fetch_model.svh"

    logic clk, reset, psel, penable, pwrite, pready, pslverr;
    fetch_pkg::apb_addr_t paddr;
    logic [31:0] pwdata, prdata;
    logic [7:0] length;
    logic stall, init, resteer, branch_taken, alt_select, packet_valid;
    fetch_pkg::bip_t init_bip, resteer_bip, branch_bip, old_bip, new_bip;
    fetch_pkg::line_t alt_packet, packet_out;

    // mirror of the buffer and expected output state
    fetch_pkg::line_array_t mem_mirror;
    logic [3:0] valid_mirror;
    fetch_pkg::bip_t exp_bip, exp_old, exp_new;
    fetch_pkg::line_t exp_packet;
    logic exp_valid;
    logic [31:0] rd;
    logic err;
    step_t steps[$];
    string names[$];
    integer seed = 90370;

    fetch_align_top u_dut (.*);

    always #20 clk = ~clk;

    task automatic check_value(input string name, input logic [127:0] expected,
                               input logic [127:0] actual);
        assert (expected === actual) else begin
            $display("Mismatch %s: expected %h, actual %h", name, expected, actual);
            $display("Simulation FAILED");
            $fatal(1);
        end
    endtask

    ////////////////////////////////////////
    // APB host
    ////////////////////////////////////////

    task automatic apb_access(input logic wr, input fetch_pkg::apb_addr_t addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic slverr);
        int waited;
        @(posedge clk);
        #1;
        psel = 1'b1;
        penable = 1'b0;
        pwrite = wr;
        paddr = addr;
        pwdata = wdata;
        @(posedge clk);
        #1;
        penable = 1'b1;
        // look at the slave mid-cycle once its outputs have settled
        @(negedge clk);
        waited = 0;
        while (!pready) begin
            if (waited == TIMEOUT) begin
                $display("APB access at address %h never saw pready", addr);
                $display("Simulation FAILED");
                $fatal(1);
            end
            waited++;
            @(negedge clk);
        end
        rdata = prdata;
        slverr = pslverr;
        @(posedge clk);
        #1;
        psel = 1'b0;
        penable = 1'b0;
    endtask

    task automatic read_check(input string name, input fetch_pkg::apb_addr_t addr,
                              input logic [31:0] expected, input logic exp_err);
        logic [31:0] data;
        logic slverr;
        apb_access(1'b0, addr, '0, data, slverr);
        check_value(name, 128'(expected), 128'(data));
        check_value({name, " pslverr"}, 128'(exp_err), 128'(slverr));
    endtask

    task automatic fill_line(input int ln);
        logic [31:0] data;
        for (int w = 0; w < 4; w++) begin
            data = $random(seed);
            apb_access(1'b1, fetch_pkg::apb_addr_t'(ln*16 + w*4), data, rd, err);
            mem_mirror[ln][w*32 +: 32] = data;
        end
        valid_mirror[ln] = 1'b1;
    endtask

    ////////////////////////////////////////
    // one table row
    ////////////////////////////////////////

    task automatic apply_step(input string name, input step_t s);
        fetch_pkg::bip_t nxt;
        if (s.clear != 0) begin
            apb_access(1'b1, fetch_pkg::STATUS_ADDR, 32'(s.clear), rd, err);
            valid_mirror = valid_mirror & ~s.clear[3:0];
        end
        for (int ln = 0; ln < 4; ln++) begin
            if (s.refill[ln]) fill_line(ln);
        end
        nxt = next_ptr(exp_bip, s);
        @(posedge clk);
        #1;
        length = 8'(s.length);
        stall = s.stall[0];
        init = s.redir[2];
        resteer = s.redir[1];
        branch_taken = s.redir[0];
        init_bip = fetch_pkg::bip_t'(s.init_bip);
        resteer_bip = fetch_pkg::bip_t'(s.resteer_bip);
        branch_bip = fetch_pkg::bip_t'(s.branch_bip);
        alt_select = s.alt[0];
        alt_packet = {$random(seed), $random(seed), $random(seed), $random(seed)};
        if (!s.stall[0]) begin
            if (window_ok(valid_mirror, nxt)) begin
                exp_packet = s.alt[0] ? alt_packet : rotate_window(mem_mirror, nxt);
                exp_valid = 1'b1;
                exp_old = exp_bip;
                exp_new = nxt;
                exp_bip = nxt;
            end else begin
                exp_valid = 1'b0;
                if (s.redir != 0) exp_bip = nxt;
            end
        end
        @(posedge clk);
        #1;
        check_value({name, " packet_out"}, exp_packet, packet_out);
        check_value({name, " packet_valid"}, 128'(exp_valid), 128'(packet_valid));
        check_value({name, " old_bip"}, 128'(exp_old), 128'(old_bip));
        check_value({name, " new_bip"}, 128'(exp_new), 128'(new_bip));
        // park the stage between rows
        stall = 1'b1;
        init = 1'b0;
        resteer = 1'b0;
        branch_taken = 1'b0;
        alt_select = 1'b0;
        length = '0;
    endtask

    task automatic add_step(input string name, input step_t s);
        names.push_back(name);
        steps.push_back(s);
    endtask

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        {psel, penable, pwrite, paddr, pwdata} = '0;
        {length, init, init_bip, resteer, resteer_bip, branch_taken, branch_bip} = '0;
        {alt_packet, alt_select} = '0;
        stall = 1'b1;
        {exp_bip, exp_old, exp_new, exp_packet, exp_valid, valid_mirror} = '0;

        // length, stall, redir, init/resteer/branch target, alt, clear, refill
        add_step("seq_start",        '{0, 0, 0, 0, 0, 0, 0, 0, 0});
        add_step("seq_len5",         '{5, 0, 0, 0, 0, 0, 0, 0, 0});
        add_step("seq_len11",        '{11, 0, 0, 0, 0, 0, 0, 0, 0});
        add_step("seq_len15",        '{15, 0, 0, 0, 0, 0, 0, 0, 0});
        add_step("seq_window_wrap",  '{23, 0, 0, 0, 0, 0, 0, 0, 0});
        add_step("seq_ptr_wrap",     '{12, 0, 0, 0, 0, 0, 0, 0, 0});
        add_step("init_only",        '{9, 0, 4, 20, 0, 0, 0, 0, 0});
        add_step("all_redirects",    '{3, 0, 7, 33, 45, 60, 0, 0, 0});
        add_step("resteer_branch",   '{0, 0, 3, 0, 45, 7, 0, 0, 0});
        add_step("init_branch",      '{0, 0, 5, 10, 0, 50, 0, 0, 0});
        add_step("branch_only",      '{3, 0, 1, 0, 0, 60, 0, 0, 0});
        add_step("resteer_only",     '{4, 0, 2, 0, 12, 0, 0, 0, 0});
        add_step("stall_length",     '{7, 1, 0, 0, 0, 0, 0, 0, 0});
        add_step("stall_redirect",   '{2, 1, 7, 50, 40, 30, 1, 0, 0});
        add_step("clear_next_line",  '{8, 0, 0, 0, 0, 0, 0, 4, 0});
        add_step("still_missing",    '{8, 0, 0, 0, 0, 0, 0, 0, 0});
        add_step("refill_resume",    '{8, 0, 0, 0, 0, 0, 0, 0, 4});
        add_step("redirect_missing", '{0, 0, 1, 0, 0, 16, 0, 2, 0});
        add_step("refill_at_target", '{0, 0, 0, 0, 0, 0, 0, 0, 2});
        add_step("alt_packet",       '{6, 0, 0, 0, 0, 0, 1, 0, 0});
        add_step("alt_branch",       '{0, 0, 1, 0, 0, 50, 1, 0, 0});
        add_step("seq_after_alt",    '{10, 0, 0, 0, 0, 0, 0, 0, 0});

        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;
        check_value("reset packet_out", '0, packet_out);
        check_value("reset flags", '0, 128'({packet_valid, old_bip, new_bip, pslverr}));

        ////////////////////////////////////////
        // APB fill, readback and status
        ////////////////////////////////////////
        for (int ln = 0; ln < 4; ln++) fill_line(ln);
        for (int a = 0; a < 64; a += 4) begin
            read_check("readback", fetch_pkg::apb_addr_t'(a), mem_mirror[a/16][(a%16)*8 +: 32],
                       1'b0);
        end
        read_check("status_full", fetch_pkg::STATUS_ADDR, 32'hf, 1'b0);
        apb_access(1'b1, fetch_pkg::STATUS_ADDR, 32'h5, rd, err);
        valid_mirror = 4'ha;
        read_check("status_cleared", fetch_pkg::STATUS_ADDR, 32'ha, 1'b0);
        apb_access(1'b1, 8'h80, 32'hf, rd, err);
        check_value("bad_addr_write pslverr", 128'(1'b1), 128'(err));
        read_check("bad_addr_read", 8'h80, 32'h0, 1'b1);
        read_check("status_after_bad", fetch_pkg::STATUS_ADDR, 32'ha, 1'b0);
        fill_line(0);
        fill_line(2);
        read_check("status_refilled", fetch_pkg::STATUS_ADDR, 32'hf, 1'b0);

        for (int i = 0; i < steps.size(); i++) apply_step(names[i], steps[i]);

        $display("Simulation PASSED");
        $finish;
    end

endmodule
